/* filelist.f */
+incdir+src
src/spi_pkg.sv
src/spi_master.sv
src/spi_arbiter.sv
src/status_poller.sv
src/spi_subsystem.sv
bench/spi_slave_model.sv
bench/tb_spi_subsystem.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -f filelist.f \
  --top-module tb_spi_subsystem -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" sim.log; then
  exit 1
fi
exit 0

/* bench/tb_spi_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "spi_settings.svh"

module tb_spi_subsystem;

  localparam int num_cmds = 300;
  localparam int b2b_start = 200;  // No idle gaps from here on.
  localparam int watchdog_cycles =
    num_cmds * (24 * `SPI_CLK_DIV + 10) + 50 * `POLL_INTERVAL;

  logic              clk = 1'b0;
  logic              rst_n;
  spi_pkg::spi_cmd_t host_cmd;
  logic              host_cmd_vld;
  logic              host_cmd_rdy;
  logic              host_read_vld;
  logic [7:0]        read_data;
  logic [7:0]        status_data;
  logic              status_vld;
  logic              sclk;
  logic              cs;
  logic              mosi;
  logic              miso;
  int                write_frames;
  int                frame_errors;

  logic [7:0] model [8];  // Register contents as the host sees them.
  logic [7:0] exp_reads [$];
  logic [7:0] exp_status [$];
  logic       b2b_phase;
  int         host_writes = 0;
  int         host_reads = 0;
  int         read_pulses = 0;
  int         b2b_status = 0;
  int         data_errors = 0;
  int         reset_errors;
  int         count_errors;

  spi_subsystem u_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .host_cmd      (host_cmd),
    .host_cmd_vld  (host_cmd_vld),
    .host_cmd_rdy  (host_cmd_rdy),
    .host_read_vld (host_read_vld),
    .read_data     (read_data),
    .status_data   (status_data),
    .status_vld    (status_vld),
    .sclk          (sclk),
    .cs            (cs),
    .mosi          (mosi),
    .miso          (miso)
  );

  spi_slave_model u_slave (
    .sclk         (sclk),
    .cs           (cs),
    .mosi         (mosi),
    .miso         (miso),
    .write_frames (write_frames),
    .frame_errors (frame_errors)
  );

  always #4 clk = ~clk;

  function automatic int value_error(input string test, input int exp_v, input int act_v);
    value_error = 0;
    assert (exp_v == act_v)
    else
    begin
      $display("Mismatch %s: expected %0h, actual %0h", test, exp_v, act_v);
      value_error = 1;
    end
  endfunction

  task automatic check_idle_outputs(input string phase);
    reset_errors += value_error({"cs ", phase}, 1, int'(cs));
    reset_errors += value_error({"sclk ", phase}, 0, int'(sclk));
    reset_errors += value_error({"host_cmd_rdy ", phase}, 0, int'(host_cmd_rdy));
    reset_errors += value_error({"status_vld ", phase}, 0, int'(status_vld));
    reset_errors += value_error({"status_data ", phase}, 0, int'(status_data));
  endtask

  // Hold the command until the arbiter takes it.
  task automatic send_cmd(input spi_pkg::spi_cmd_t c);
    host_cmd = c;
    host_cmd_vld = 1'b1;
    @(negedge clk);
    while (!host_cmd_rdy)
      @(negedge clk);
    @(posedge clk);
    #1;
    host_cmd_vld = 1'b0;
  endtask

  // Model update and checks at mid-cycle.
  always @(negedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 8; i++)
        model[i] = u_slave.regs[i];
    end
    else
    begin
      if (host_cmd_vld && host_cmd_rdy)
      begin
        if (host_cmd.write)
        begin
          model[host_cmd.addr] = host_cmd.wdata;
          host_writes++;
        end
        else
        begin
          exp_reads.push_back(model[host_cmd.addr]);
          host_reads++;
        end
      end
      if (u_dut.poll_gnt)
        exp_status.push_back(model[3'(`POLL_ADDR)]);  // Value at grant time.
      if (host_read_vld)
      begin
        read_pulses++;
        assert (exp_reads.size() > 0)
        else
        begin
          $display("Read data returned with no host read pending");
          data_errors++;
        end
        if (exp_reads.size() > 0)
          data_errors += value_error("read_after_write", int'(exp_reads.pop_front()),
                                     int'(read_data));
      end
      if (status_vld)
      begin
        if (b2b_phase)
          b2b_status++;
        assert (exp_status.size() > 0)
        else
        begin
          $display("Status update arrived with no poll granted");
          data_errors++;
        end
        if (exp_status.size() > 0)
          data_errors += value_error("status_poll", int'(exp_status.pop_front()),
                                     int'(status_data));
      end
    end
  end

  initial
  begin
    spi_pkg::spi_cmd_t c;
    logic [31:0]       r;
    int                gap;
    int                seed;
    seed = 32'hfc81_574b;
    rst_n = 1'b0;
    host_cmd = '0;
    host_cmd_vld = 1'b0;
    b2b_phase = 1'b0;
    reset_errors = 0;
    count_errors = 0;
    repeat (3)
    begin
      @(posedge clk);
      #1;
      check_idle_outputs("during reset");
    end
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    check_idle_outputs("after reset");
    for (int n = 0; n < num_cmds; n++)
    begin
      r = $random(seed);
      c.write = r[0];
      c.addr = r[3:1];
      c.wdata = r[11:4];
      gap = int'(r[31:16] % 16'd6);
      if (n >= b2b_start)
      begin
        b2b_phase = 1'b1;
        gap = 0;
      end
      repeat (gap) @(posedge clk);
      if (gap != 0)
        #1;
      send_cmd(c);
    end
    while (exp_reads.size() != 0 || exp_status.size() != 0 || cs == 1'b0)
      @(posedge clk);
    repeat (4) @(posedge clk);
    count_errors += value_error("read_count", host_reads, read_pulses);
    count_errors += value_error("write_frame_count", host_writes, write_frames);
    assert (b2b_status > 0)
    else
    begin
      $display("No status poll completed while the host ran back to back");
      count_errors++;
    end
    $display("Error counts: %0d reset, %0d data, %0d count, %0d frame",
             reset_errors, data_errors, count_errors, frame_errors);
    if (reset_errors + data_errors + count_errors + frame_errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  initial
  begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("Timeout: run did not finish within %0d clock cycles", watchdog_cycles);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/spi_slave_model.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_slave_model (
  input  wire  sclk,
  input  wire  cs,
  input  wire  mosi,
  output logic miso,
  output int   write_frames,
  output int   frame_errors
);

  logic [7:0]  regs [8];
  logic [11:0] rx_bits;
  logic [7:0]  tx_bits;
  logic        sclk_q;
  logic        cs_q;
  logic        is_read;
  int          rises;

  initial
  begin
    for (int i = 0; i < 8; i++)
      regs[i] = 8'h3c ^ 8'(i * 71);  // Distinct per address.
    miso = 1'b0;
    write_frames = 0;
    frame_errors = 0;
    rises = 0;
    is_read = 1'b0;
    sclk_q = sclk;
    cs_q = cs;
    forever
    begin
      @(sclk or cs);
      if (cs === 1'b0 && sclk !== sclk_q)
      begin
        if (sclk)
        begin
          rx_bits = {rx_bits[10:0], mosi};
          rises++;
          if (rises == 4)
          begin
            is_read = !rx_bits[3];  // Header complete.
            tx_bits = regs[rx_bits[2:0]];
          end
        end
        else if (is_read && rises >= 4 && rises < 12)
        begin
          miso = tx_bits[7];  // Mode 0 changes miso after the falling edge.
          tx_bits = {tx_bits[6:0], 1'b0};
        end
      end
      if (cs === 1'b0 && cs_q === 1'b1)
      begin
        assert (sclk === 1'b0)
        else
        begin
          $display("Frame error: sclk was not low when cs fell at %0t", $time);
          frame_errors++;
        end
        rises = 0;
        is_read = 1'b0;
      end
      else if (cs === 1'b1 && cs_q === 1'b0)
      begin
        assert (rises == 12)
        else
        begin
          $display("Frame error: %0d rising sclk edges in a frame instead of 12", rises);
          frame_errors++;
        end
        if (rises == 12 && rx_bits[11])
        begin
          regs[rx_bits[10:8]] = rx_bits[7:0];
          write_frames++;
        end
      end
      sclk_q = sclk;
      cs_q = cs;
    end
  end

endmodule

`default_nettype wire

/* src/spi_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_subsystem (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire spi_pkg::spi_cmd_t host_cmd,
  input  wire                    host_cmd_vld,
  output logic                   host_cmd_rdy,
  output logic                   host_read_vld,
  output logic [7:0]             read_data,
  output logic [7:0]             status_data,
  output logic                   status_vld,
  output logic                   sclk,
  output logic                   cs,
  output logic                   mosi,
  input  wire                    miso
);

  logic              poll_req;
  logic [2:0]        poll_addr;
  logic              poll_gnt;
  logic              poll_rsp_vld;
  spi_pkg::spi_cmd_t cmd;
  logic              cmd_vld;
  logic              cmd_rdy;
  logic              read_vld;

  status_poller u_poller (
    .clk          (clk),
    .rst_n        (rst_n),
    .poll_req     (poll_req),
    .poll_addr    (poll_addr),
    .poll_gnt     (poll_gnt),
    .poll_rsp_vld (poll_rsp_vld),
    .read_data    (read_data),
    .status_data  (status_data),
    .status_vld   (status_vld)
  );

  spi_arbiter u_arbiter (
    .clk           (clk),
    .rst_n         (rst_n),
    .host_cmd      (host_cmd),
    .host_cmd_vld  (host_cmd_vld),
    .host_cmd_rdy  (host_cmd_rdy),
    .poll_req      (poll_req),
    .poll_addr     (poll_addr),
    .poll_gnt      (poll_gnt),
    .cmd           (cmd),
    .cmd_vld       (cmd_vld),
    .cmd_rdy       (cmd_rdy),
    .read_vld      (read_vld),
    .host_read_vld (host_read_vld),
    .poll_rsp_vld  (poll_rsp_vld)
  );

  // Read data is shared; the valid pulses tell the owners apart.
  spi_master u_master (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

endmodule

`default_nettype wire

/* src/status_poller.sv */
`timescale 1ns/1ps
`default_nettype none

`include "spi_settings.svh"

module status_poller (
  input  wire        clk,
  input  wire        rst_n,
  output logic       poll_req,
  output logic [2:0] poll_addr,
  input  wire        poll_gnt,
  input  wire        poll_rsp_vld,
  input  wire  [7:0] read_data,
  output logic [7:0] status_data,
  output logic       status_vld
);

  localparam int cnt_w = $clog2(`POLL_INTERVAL + 1);
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`POLL_INTERVAL - 1);

  logic [cnt_w-1:0] cnt_q;
  logic             req_q;
  logic             wait_q;  // Granted and waiting for the response.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt_q       <= '0;
      req_q       <= 1'b0;
      wait_q      <= 1'b0;
      status_data <= 8'h00;
      status_vld  <= 1'b0;
    end
    else
    begin
      status_vld <= 1'b0;
      if (wait_q)
      begin
        if (poll_rsp_vld)
        begin
          wait_q      <= 1'b0;
          cnt_q       <= '0;
          status_data <= read_data;
          status_vld  <= 1'b1;
        end
      end
      else if (req_q)
      begin
        if (poll_gnt)
        begin
          req_q  <= 1'b0;
          wait_q <= 1'b1;
        end
      end
      else if (cnt_q == cnt_last)
      begin
        req_q <= 1'b1;  // Held until granted.
      end
      else
      begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign poll_req  = req_q;
  assign poll_addr = 3'(`POLL_ADDR);

endmodule

`default_nettype wire

/* src/spi_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_arbiter (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire spi_pkg::spi_cmd_t host_cmd,
  input  wire                    host_cmd_vld,
  output logic                   host_cmd_rdy,
  input  wire                    poll_req,
  input  wire [2:0]              poll_addr,
  output logic                   poll_gnt,
  output spi_pkg::spi_cmd_t      cmd,
  output logic                   cmd_vld,
  input  wire                    cmd_rdy,
  input  wire                    read_vld,
  output logic                   host_read_vld,
  output logic                   poll_rsp_vld
);

  spi_pkg::spi_src_e prio_q;   // Preferred source on a tie.
  spi_pkg::spi_src_e owner_q;  // Source of the frame in flight.

  spi_pkg::spi_cmd_t poll_cmd;
  logic host_win;
  logic poll_win;
  logic xfer;

  // Status poll is always a read.
  assign poll_cmd = '{write: 1'b0, addr: poll_addr, wdata: 8'h00};

  assign host_win = host_cmd_vld && (!poll_req || (prio_q == spi_pkg::src_host));
  assign poll_win = poll_req && !host_win;

  assign cmd     = host_win ? host_cmd : poll_cmd;
  assign cmd_vld = host_cmd_vld || poll_req;
  assign xfer    = cmd_vld && cmd_rdy;

  assign host_cmd_rdy = cmd_rdy && host_win;  // Loser never sees ready.
  assign poll_gnt     = cmd_rdy && poll_win;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      prio_q  <= spi_pkg::src_host;
      owner_q <= spi_pkg::src_host;
    end
    else if (xfer)
    begin
      if (host_win)
      begin
        owner_q <= spi_pkg::src_host;
        prio_q  <= spi_pkg::src_poll;
      end
      else
      begin
        owner_q <= spi_pkg::src_poll;
        prio_q  <= spi_pkg::src_host;
      end
    end
  end

  // Response goes back to whoever started the frame.
  assign host_read_vld = read_vld && (owner_q == spi_pkg::src_host);
  assign poll_rsp_vld  = read_vld && (owner_q == spi_pkg::src_poll);

endmodule

`default_nettype wire

/* src/spi_master.sv */
`timescale 1ns/1ps
`default_nettype none

`include "spi_settings.svh"

module spi_master (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire spi_pkg::spi_cmd_t cmd,
  input  wire                    cmd_vld,
  output logic                   cmd_rdy,
  output logic                   sclk,
  output logic                   cs,
  output logic                   mosi,
  input  wire                    miso,
  output logic                   read_vld,
  output logic [7:0]             read_data
);

  localparam int div_w = $clog2(`SPI_CLK_DIV) + 1;
  localparam logic [div_w-1:0] div_last = div_w'(`SPI_CLK_DIV - 1);
  localparam logic [3:0] hdr_last = 4'(`SPI_READ_HDR_BITS - 1);
  localparam logic [3:0] frame_last = 4'(`SPI_CMD_BITS - 1);

  spi_pkg::spi_state_e state_q;
  spi_pkg::spi_state_e state_d;

  logic [div_w-1:0] div_cnt_q;
  logic [3:0]       bit_cnt_q;
  logic             sclk_q;
  logic             read_q;
  logic [11:0]      tx_q;
  logic [7:0]       rx_q;

  logic active;
  logic half_done;
  logic sclk_rise;
  logic sclk_fall;
  logic xfer;

  assign xfer   = cmd_vld && (state_q == spi_pkg::st_idle);
  assign active = (state_q == spi_pkg::st_shift) || (state_q == spi_pkg::st_sample);

  // sclk toggles at the end of every half period.
  assign half_done = active && (div_cnt_q == div_last);
  assign sclk_rise = half_done && !sclk_q;
  assign sclk_fall = half_done && sclk_q;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      spi_pkg::st_idle:
      begin
        if (cmd_vld)
        begin
          state_d = spi_pkg::st_setup;
        end
      end
      spi_pkg::st_setup:
      begin
        state_d = spi_pkg::st_shift;
      end
      spi_pkg::st_shift:
      begin
        if (sclk_fall)
        begin
          if (bit_cnt_q == frame_last)
          begin
            state_d = spi_pkg::st_finish;
          end
          else if (read_q && (bit_cnt_q == hdr_last))
          begin
            state_d = spi_pkg::st_sample;  // Turn to miso after the header.
          end
        end
      end
      spi_pkg::st_sample:
      begin
        if (sclk_fall && (bit_cnt_q == frame_last))
        begin
          state_d = spi_pkg::st_finish;
        end
      end
      spi_pkg::st_finish:
      begin
        state_d = spi_pkg::st_idle;
      end
      default:
      begin
        state_d = spi_pkg::st_idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q   <= spi_pkg::st_idle;
      div_cnt_q <= '0;
      bit_cnt_q <= '0;
      sclk_q    <= 1'b0;
      read_q    <= 1'b0;
      tx_q      <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (xfer)
      begin
        read_q    <= !cmd.write;
        // Reads send zeros after the header.
        tx_q      <= {cmd.write, cmd.addr, cmd.write ? cmd.wdata : 8'h00};
        bit_cnt_q <= '0;
        div_cnt_q <= '0;
        sclk_q    <= 1'b0;
      end
      else if (active)
      begin
        if (half_done)
        begin
          div_cnt_q <= '0;
          sclk_q    <= !sclk_q;
        end
        else
        begin
          div_cnt_q <= div_cnt_q + 1'b1;
        end
        if (sclk_fall)
        begin
          tx_q      <= {tx_q[10:0], 1'b0};  // Next bit after falling edge.
          bit_cnt_q <= bit_cnt_q + 1'b1;
        end
      end
    end
  end

  // Read data arrives msb first.
  always_ff @(posedge clk)
  begin
    if ((state_q == spi_pkg::st_sample) && sclk_rise)
    begin
      rx_q <= {rx_q[6:0], miso};
    end
  end

  assign cmd_rdy   = (state_q == spi_pkg::st_idle);
  assign cs        = (state_q == spi_pkg::st_idle) || (state_q == spi_pkg::st_finish);
  assign sclk      = sclk_q;
  assign mosi      = tx_q[11];
  assign read_vld  = (state_q == spi_pkg::st_finish) && read_q;
  assign read_data = rx_q;

endmodule

`default_nettype wire

/* src/spi_pkg.sv */
`default_nettype none

package spi_pkg;

  // Command word as it goes out msb first.
  typedef struct packed {
    logic       write;   // 1 = write, 0 = read.
    logic [2:0] addr;
    logic [7:0] wdata;   // Ignored for reads.
  } spi_cmd_t;

  // Frame sequencer states.
  typedef enum logic [2:0] {
    st_idle   = 3'd0,
    st_setup  = 3'd1,  // cs low with the first bit on mosi.
    st_shift  = 3'd2,  // Bits going out.
    st_sample = 3'd3,  // Read data coming in.
    st_finish = 3'd4   // cs high again.
  } spi_state_e;

  // Owner of the current SPI transfer.
  typedef enum logic {
    src_host = 1'b0,
    src_poll = 1'b1
  } spi_src_e;

endpackage

`default_nettype wire

/* src/spi_settings.svh */
`ifndef SPI_SETTINGS_SVH
`define SPI_SETTINGS_SVH

// Clk cycles per half sclk period.
// One frame takes 24 * SPI_CLK_DIV + 2 cycles from transfer to cs rise.
`define SPI_CLK_DIV 4

// Idle clk cycles between the last status response and the next poll.
`define POLL_INTERVAL 200

// Register the status poller reads.
`define POLL_ADDR 3

// Command word layout.
`define SPI_CMD_BITS 12
`define SPI_DATA_BITS 8
`define SPI_ADDR_BITS 3

// A read shifts the flag and the address out before sampling.
`define SPI_READ_HDR_BITS 4

`endif
